// File: filelist.f
+incdir+logic
logic/rv_mem_pkg.sv
logic/data_ram.sv
logic/mem_stage.sv
logic/writeback_stage.sv
logic/mem_wb_top.sv
testbench/mem_stage_chk.sv
testbench/tb_mem_wb.sv

// File: logic/data_ram.sv
`timescale 1ns/1ps
`include "rv_mem_cfg.svh"

module data_ram (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_start,
    input  logic                cmd_write,
    output logic                cmd_ready,
    input  logic [`XLEN-1:0]    mem_addr,
    input  logic [`XLEN-1:0]    mem_wdata,
    input  logic [`XLEN-1:0]    mem_wmask,
    output logic [`XLEN-1:0]    rdata,
    output logic                rdata_valid
);

    localparam int AW = $clog2(`RAM_WORDS);
    localparam int BW = $clog2(`RAM_BUSY + 1);
    localparam int LW = $clog2(`RAM_READ_LAT + 1);

    logic [`XLEN-1:0]   mem [`RAM_WORDS];
    logic [AW-1:0]      word_idx;
    logic               accept;
    logic [BW-1:0]      busy_cnt;
    logic [LW-1:0]      lat_cnt;
    logic [`XLEN-1:0]   rd_word;

    assign word_idx = mem_addr[AW+1:2];    // byte offset bits are ignored
    assign accept   = cmd_start & cmd_ready;

    // ~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (accept && cmd_write)
            mem[word_idx] <= (mem[word_idx] & ~mem_wmask) | (mem_wdata & mem_wmask);
        if (accept && !cmd_write)
            rd_word <= mem[word_idx];    // read word is held until the pulse
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // busy and read timing
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_cnt <= '0;
        end else if (accept) begin
            busy_cnt <= BW'(`RAM_BUSY);
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lat_cnt <= '0;
        end else if (accept && !cmd_write) begin
            lat_cnt <= LW'(`RAM_READ_LAT);
        end else if (lat_cnt != '0) begin
            lat_cnt <= lat_cnt - 1'b1;
        end
    end

    assign cmd_ready   = (busy_cnt == '0);
    // last count of the window, so the pulse lands RAM_READ_LAT edges after acceptance
    assign rdata_valid = (lat_cnt == LW'(1));
    assign rdata       = rd_word;

endmodule

// File: logic/mem_stage.sv
`timescale 1ns/1ps
`include "rv_mem_cfg.svh"

module mem_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 branch_hazard,

    input  logic [`XLEN-1:0]     in_pc,
    input  logic [`XLEN-1:0]     in_rs2_data,
    input  logic [`XLEN-1:0]     in_alu_out,
    input  logic                 in_br_flg,
    input  logic [`XLEN-1:0]     in_br_target,
    input  rv_mem_pkg::mem_op_t  in_mem_op,
    input  logic                 in_rf_wen,
    input  rv_mem_pkg::wb_sel_t  in_wb_sel,
    input  logic [4:0]           in_wb_addr,
    input  logic                 in_jmp_flg,
    output logic                 stall,

    output logic [`XLEN-1:0]     wb_pc,
    output logic [`XLEN-1:0]     wb_read_data,
    output logic [`XLEN-1:0]     wb_alu_out,
    output logic                 wb_br_flg,
    output logic [`XLEN-1:0]     wb_br_target,
    output logic                 wb_rf_wen,
    output rv_mem_pkg::wb_sel_t  wb_sel,
    output logic [4:0]           wb_addr,
    output logic                 wb_jmp_flg,

    output logic                 cmd_start,
    output logic                 cmd_write,
    input  logic                 cmd_ready,
    output logic [`XLEN-1:0]     mem_addr,
    output logic [`XLEN-1:0]     mem_wdata,
    output logic [`XLEN-1:0]     mem_wmask,
    input  logic [`XLEN-1:0]     rdata,
    input  logic                 rdata_valid
);
    import rv_mem_pkg::*;

    localparam logic [1:0] S_IDLE       = 2'd0;
    localparam logic [1:0] S_WAIT_READY = 2'd1;
    localparam logic [1:0] S_WAIT_RDATA = 2'd2;

    logic [1:0]         state;
    logic [1:0]         state_nxt;

    // the instruction as seen after a possible flush
    mem_op_t            cur_op;
    logic               cur_rf_wen;
    logic               cur_br_flg;
    logic               cur_jmp_flg;
    logic               cur_store;
    logic               cur_load;

    // copy of the instruction taken when the stage leaves idle
    logic [`XLEN-1:0]   save_pc;
    logic [`XLEN-1:0]   save_rs2_data;
    logic [`XLEN-1:0]   save_alu_out;
    logic               save_br_flg;
    logic [`XLEN-1:0]   save_br_target;
    mem_op_t            save_op;
    logic               save_rf_wen;
    wb_sel_t            save_wb_sel;
    logic [4:0]         save_wb_addr;
    logic               save_jmp_flg;
    logic               save_store;

    logic               done_cur;
    logic               done_save;
    logic [`XLEN-1:0]   load_data;

    function automatic logic [`XLEN-1:0] wmask_of(mem_op_t op);
        case (op)
            MEM_SB:  return {{(`XLEN-8){1'b0}}, 8'hff};
            MEM_SH:  return {{(`XLEN-16){1'b0}}, 16'hffff};
            default: return '1;
        endcase
    endfunction

    assign cur_op      = branch_hazard ? MEM_NONE : in_mem_op;
    assign cur_rf_wen  = in_rf_wen  & ~branch_hazard;
    assign cur_br_flg  = in_br_flg  & ~branch_hazard;
    assign cur_jmp_flg = in_jmp_flg & ~branch_hazard;
    assign cur_store   = is_store(cur_op);
    assign cur_load    = is_load(cur_op);
    assign save_store  = is_store(save_op);

    // ~~~~~~~~~~~~~~~~~~~~
    // completion and stall
    // ~~~~~~~~~~~~~~~~~~~~
    // a store finishes the cycle the RAM takes it, a load only when its data is back
    assign done_cur  = (state == S_IDLE) && (!(cur_store || cur_load) || (cur_store && cmd_ready));
    assign done_save = ((state == S_WAIT_READY) && save_store && cmd_ready) ||
                       ((state == S_WAIT_RDATA) && rdata_valid);
    assign stall     = ~(done_cur | done_save);

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (cur_load)
                    state_nxt = cmd_ready ? S_WAIT_RDATA : S_WAIT_READY;
                else if (cur_store && !cmd_ready)
                    state_nxt = S_WAIT_READY;
            end
            S_WAIT_READY: begin
                if (cmd_ready)
                    state_nxt = save_store ? S_IDLE : S_WAIT_RDATA;
            end
            S_WAIT_RDATA: begin
                if (rdata_valid)
                    state_nxt = S_IDLE;
            end
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= S_IDLE;
        else
            state <= state_nxt;
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && !done_cur) begin
            save_pc        <= in_pc;
            save_rs2_data  <= in_rs2_data;
            save_alu_out   <= in_alu_out;
            save_br_flg    <= cur_br_flg;
            save_br_target <= in_br_target;
            save_op        <= cur_op;
            save_rf_wen    <= cur_rf_wen;
            save_wb_sel    <= in_wb_sel;
            save_wb_addr   <= in_wb_addr;
            save_jmp_flg   <= cur_jmp_flg;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // command port
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        cmd_start = 1'b0;
        cmd_write = 1'b0;
        case (state)
            S_IDLE: begin
                cmd_start = cur_store | cur_load;
                cmd_write = cur_store;
            end
            S_WAIT_READY: begin
                cmd_start = 1'b1;    // held until the RAM takes it
                cmd_write = save_store;
            end
            default: ;
        endcase
    end

    assign mem_addr  = (state == S_IDLE) ? in_alu_out  : save_alu_out;
    assign mem_wdata = (state == S_IDLE) ? in_rs2_data : save_rs2_data;
    assign mem_wmask = (state == S_IDLE) ? wmask_of(cur_op) : wmask_of(save_op);

    // sub-word data sits in the low lanes
    always_comb begin
        case (save_op)
            MEM_LB:  load_data = {{(`XLEN-8){rdata[7]}}, rdata[7:0]};
            MEM_LBU: load_data = {{(`XLEN-8){1'b0}}, rdata[7:0]};
            MEM_LH:  load_data = {{(`XLEN-16){rdata[15]}}, rdata[15:0]};
            MEM_LHU: load_data = {{(`XLEN-16){1'b0}}, rdata[15:0]};
            default: load_data = rdata;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // writeback registers
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_rf_wen  <= 1'b0;
            wb_br_flg  <= 1'b0;
            wb_jmp_flg <= 1'b0;
            wb_sel     <= WB_NONE;
        end else if (done_cur) begin
            wb_rf_wen  <= cur_rf_wen;
            wb_br_flg  <= cur_br_flg;
            wb_jmp_flg <= cur_jmp_flg;
            wb_sel     <= in_wb_sel;
        end else if (done_save) begin
            wb_rf_wen  <= save_rf_wen;
            wb_br_flg  <= save_br_flg;
            wb_jmp_flg <= save_jmp_flg;
            wb_sel     <= save_wb_sel;
        end else begin
            wb_rf_wen  <= 1'b0;    // nothing finished, pass a bubble on
            wb_br_flg  <= 1'b0;
            wb_jmp_flg <= 1'b0;
            wb_sel     <= WB_NONE;
        end
    end

    always_ff @(posedge clk) begin
        wb_read_data <= load_data;
        if (done_cur) begin
            wb_pc        <= in_pc;
            wb_alu_out   <= in_alu_out;
            wb_br_target <= in_br_target;
            wb_addr      <= in_wb_addr;
        end else begin
            wb_pc        <= save_pc;
            wb_alu_out   <= save_alu_out;
            wb_br_target <= save_br_target;
            wb_addr      <= save_wb_addr;
        end
    end

endmodule

// File: logic/mem_wb_top.sv
`timescale 1ns/1ps
`include "rv_mem_cfg.svh"

module mem_wb_top (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic [`XLEN-1:0]     in_pc,
    input  logic [`XLEN-1:0]     in_rs2_data,
    input  logic [`XLEN-1:0]     in_alu_out,
    input  logic                 in_br_flg,
    input  logic [`XLEN-1:0]     in_br_target,
    input  rv_mem_pkg::mem_op_t  in_mem_op,
    input  logic                 in_rf_wen,
    input  rv_mem_pkg::wb_sel_t  in_wb_sel,
    input  logic [4:0]           in_wb_addr,
    input  logic                 in_jmp_flg,
    output logic                 stall,

    output logic                 rf_we,
    output logic [4:0]           rf_waddr,
    output logic [`XLEN-1:0]     rf_wdata,
    output logic                 redirect,
    output logic [`XLEN-1:0]     redirect_pc
);
    import rv_mem_pkg::*;

    logic               branch_hazard;

    // memory stage to writeback
    logic [`XLEN-1:0]   wb_pc;
    logic [`XLEN-1:0]   wb_read_data;
    logic [`XLEN-1:0]   wb_alu_out;
    logic               wb_br_flg;
    logic [`XLEN-1:0]   wb_br_target;
    logic               wb_rf_wen;
    wb_sel_t            wb_sel;
    logic [4:0]         wb_addr;
    logic               wb_jmp_flg;

    // command port
    logic               cmd_start;
    logic               cmd_write;
    logic               cmd_ready;
    logic [`XLEN-1:0]   mem_addr;
    logic [`XLEN-1:0]   mem_wdata;
    logic [`XLEN-1:0]   mem_wmask;
    logic [`XLEN-1:0]   rdata;
    logic               rdata_valid;

    mem_stage u_mem_stage (
        .clk, .rst_n, .branch_hazard,
        .in_pc, .in_rs2_data, .in_alu_out, .in_br_flg, .in_br_target,
        .in_mem_op, .in_rf_wen, .in_wb_sel, .in_wb_addr, .in_jmp_flg,
        .stall,
        .wb_pc, .wb_read_data, .wb_alu_out, .wb_br_flg, .wb_br_target,
        .wb_rf_wen, .wb_sel, .wb_addr, .wb_jmp_flg,
        .cmd_start, .cmd_write, .cmd_ready,
        .mem_addr, .mem_wdata, .mem_wmask, .rdata, .rdata_valid
    );

    data_ram u_data_ram (
        .clk, .rst_n,
        .cmd_start, .cmd_write, .cmd_ready,
        .mem_addr, .mem_wdata, .mem_wmask, .rdata, .rdata_valid
    );

    // redirect also flushes the instruction entering the memory stage
    writeback_stage u_writeback_stage (
        .wb_rf_wen, .wb_sel, .wb_addr, .wb_pc, .wb_read_data,
        .wb_alu_out, .wb_br_flg, .wb_br_target, .wb_jmp_flg,
        .rf_we, .rf_waddr, .rf_wdata,
        .redirect, .branch_hazard, .redirect_pc
    );

endmodule

// File: logic/rv_mem_cfg.svh
`ifndef RV_MEM_CFG_SVH
`define RV_MEM_CFG_SVH

// data and address width
`define XLEN 32

// data RAM depth in words, indexed by the address bits above bit 1
`define RAM_WORDS 1024

// cycles the RAM keeps ready low after it accepts a command
`define RAM_BUSY 2

// cycles from an accepted read to its rdata_valid pulse
`define RAM_READ_LAT 3

`endif

// File: logic/rv_mem_pkg.sv
package rv_mem_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // memory operation of an instruction
    // ~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LBU  = 4'd2,
        MEM_LH   = 4'd3,
        MEM_LHU  = 4'd4,
        MEM_LW   = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // writeback source
    // ~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        WB_NONE = 2'd0,
        WB_ALU  = 2'd1,
        WB_MEM  = 2'd2,
        WB_PC   = 2'd3    // pc plus 4, the link value of a jump
    } wb_sel_t;

    function automatic logic is_store(mem_op_t op);
        return op inside {MEM_SB, MEM_SH, MEM_SW};
    endfunction

    // anything that reads memory, whatever its width or extension
    function automatic logic is_load(mem_op_t op);
        return op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
    endfunction

endpackage

// File: logic/writeback_stage.sv
`timescale 1ns/1ps
`include "rv_mem_cfg.svh"

module writeback_stage (
    input  logic                 wb_rf_wen,
    input  rv_mem_pkg::wb_sel_t  wb_sel,
    input  logic [4:0]           wb_addr,
    input  logic [`XLEN-1:0]     wb_pc,
    input  logic [`XLEN-1:0]     wb_read_data,
    input  logic [`XLEN-1:0]     wb_alu_out,
    input  logic                 wb_br_flg,
    input  logic [`XLEN-1:0]     wb_br_target,
    input  logic                 wb_jmp_flg,

    output logic                 rf_we,
    output logic [4:0]           rf_waddr,
    output logic [`XLEN-1:0]     rf_wdata,
    output logic                 redirect,
    output logic                 branch_hazard,
    output logic [`XLEN-1:0]     redirect_pc
);
    import rv_mem_pkg::*;

    logic [`XLEN-1:0] link_pc;

    // ~~~~~~~~~~~~~~~~~~~~
    // register file write
    // ~~~~~~~~~~~~~~~~~~~~
    assign link_pc  = wb_pc + `XLEN'd4;
    assign rf_we    = wb_rf_wen && (wb_addr != 5'd0);    // x0 is never written
    assign rf_waddr = wb_addr;

    always_comb begin
        case (wb_sel)
            WB_ALU:  rf_wdata = wb_alu_out;
            WB_MEM:  rf_wdata = wb_read_data;
            WB_PC:   rf_wdata = link_pc;
            default: rf_wdata = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // control redirect
    // ~~~~~~~~~~~~~~~~~~~~
    // a jump computes its target in the ALU, a branch carries its own
    assign redirect      = wb_br_flg | wb_jmp_flg;
    assign branch_hazard = redirect;
    assign redirect_pc   = wb_br_flg ? wb_br_target : wb_alu_out;

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_mem_wb -Mdir obj_dir

./obj_dir/Vtb_mem_wb > sim.log 2>&1 || true
cat sim.log

# the run counts as passed only if the pass line is in the log
grep -q "^TEST PASSED$" sim.log
echo "simulation passed"

// File: testbench/mem_stage_chk.sv
`timescale 1ns/1ps
`include "rv_mem_cfg.svh"

module mem_stage_chk (
    input logic             clk,
    input logic             rst_n,
    input logic             cmd_start,
    input logic             cmd_write,
    input logic             cmd_ready,
    input logic [`XLEN-1:0] mem_addr,
    input logic             stall,
    input logic             rdata_valid,
    input logic             branch_hazard
);

    logic rd_pending;    // a read was taken and its data is not back yet

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rd_pending <= 1'b0;
        else if (cmd_start && cmd_ready && !cmd_write)
            rd_pending <= 1'b1;
        else if (rdata_valid)
            rd_pending <= 1'b0;
    end

    no_cmd_in_rdata_wait: assert property (@(posedge clk) disable iff (!rst_n)
        rd_pending |-> !cmd_start)
        else $error("command issued while waiting for read data");

    addr_held_in_ready_wait: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_start && !cmd_ready) |=> (cmd_start && $stable(mem_addr)))
        else $error("command dropped or address moved while it waited for ready");

    // read data always completes the load
    no_stall_on_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_valid |-> !stall)
        else $error("stall high in the read data cycle");

    no_cmd_on_flush: assert property (@(posedge clk) disable iff (!rst_n)
        branch_hazard |-> !cmd_start)
        else $error("command issued by a flushed instruction");

endmodule

bind mem_stage mem_stage_chk u_mem_stage_chk (
    .clk(clk), .rst_n(rst_n), .cmd_start(cmd_start), .cmd_write(cmd_write),
    .cmd_ready(cmd_ready), .mem_addr(mem_addr), .stall(stall),
    .rdata_valid(rdata_valid), .branch_hazard(branch_hazard)
);

// File: testbench/tb_mem_wb.sv
`timescale 1ns/1ps
`include "rv_mem_cfg.svh"

module tb_mem_wb;
    import rv_mem_pkg::*;

    localparam int WAIT_LIMIT = 4 * (`RAM_READ_LAT + `RAM_BUSY) + 8;
    localparam logic [31:0] POOL_BASE = (`RAM_WORDS - 16) * 4;    // top 16 words of the RAM

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] in_pc, in_rs2_data, in_alu_out, in_br_target;
    logic        in_br_flg, in_rf_wen, in_jmp_flg;
    mem_op_t     in_mem_op;
    wb_sel_t     in_wb_sel;
    logic [4:0]  in_wb_addr;
    logic        stall, rf_we, redirect;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata, redirect_pc;

    logic [31:0] ref_mem [int];
    logic [31:0] lfsr = 32'd73821;
    logic [31:0] pc_now = 32'h1000;
    int          errors = 0;
    int          checks = 0;
    int          stall_cycles;

    mem_wb_top DUT (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // load result as the ISA defines it, data in the low lanes
    function automatic logic [31:0] extend(mem_op_t op, logic [31:0] w);
        case (op)
            MEM_LB:  return 32'($signed(w[7:0]));
            MEM_LBU: return {24'h0, w[7:0]};
            MEM_LH:  return 32'($signed(w[15:0]));
            MEM_LHU: return {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic ref_write(mem_op_t op, logic [31:0] addr, logic [31:0] data);
        logic [31:0] m;
        logic [31:0] old;
        m = (op == MEM_SB) ? 32'h0000_00ff : (op == MEM_SH) ? 32'h0000_ffff : 32'hffff_ffff;
        old = ref_mem.exists(addr[31:2]) ? ref_mem[addr[31:2]] : 32'h0;
        ref_mem[addr[31:2]] = (old & ~m) | (data & m);
    endtask

    task automatic end_run();
        $display("errors: %0d  checks: %0d", errors, checks);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    endtask

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // called just after a falling edge, returns at the falling edge after consumption
    task automatic issue(mem_op_t op, logic [31:0] rs2, logic [31:0] alu, logic br,
                         logic [31:0] tgt, logic wen, wb_sel_t sel, logic [4:0] rd, logic jmp);
        int n;
        n = 0;
        in_pc = pc_now;
        in_mem_op = op;
        in_rs2_data = rs2;
        in_alu_out = alu;
        in_br_flg = br;
        in_br_target = tgt;
        in_rf_wen = wen;
        in_wb_sel = sel;
        in_wb_addr = rd;
        in_jmp_flg = jmp;
        #1;
        while (stall && n < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            n++;
        end
        stall_cycles = n;
        if (stall) begin
            $display("timeout: stall stayed high for a %s instruction", op.name());
            errors++;
            end_run();
        end else begin
            pc_now += 4;
            @(negedge clk);
        end
    endtask

    task automatic bubble();
        issue(MEM_NONE, 0, 0, 1'b0, 0, 1'b0, WB_NONE, 5'd0, 1'b0);
    endtask

    task automatic expect_wb();
        int n;
        n = 0;
        while (!(rf_we || redirect) && n < WAIT_LIMIT) begin
            in_mem_op = MEM_NONE;    // hold a bubble so nothing is issued twice
            in_rf_wen = 1'b0;
            in_br_flg = 1'b0;
            in_jmp_flg = 1'b0;
            @(negedge clk);
            n++;
        end
        if (!(rf_we || redirect)) begin
            $display("timeout: no register write or redirect came out of writeback");
            errors++;
            end_run();
        end
    endtask

    task automatic check_write(logic [4:0] rd, logic [31:0] exp);
        if (rd != 5'd0) begin
            expect_wb();
            check("rf_waddr", rf_waddr, rd);
            check("rf_wdata", rf_wdata, exp);
        end else begin
            check("rf_we", rf_we, 0);
        end
    endtask

    task automatic run_alu(logic [4:0] rd, logic [31:0] val);
        issue(MEM_NONE, 0, val, 1'b0, 0, 1'b1, WB_ALU, rd, 1'b0);
        check_write(rd, val);
    endtask

    task automatic run_store(mem_op_t op, logic [31:0] addr, logic [31:0] data);
        issue(op, data, addr, 1'b0, 0, 1'b0, WB_NONE, 5'd0, 1'b0);
        ref_write(op, addr, data);
        check("rf_we", rf_we, 0);
    endtask

    task automatic run_load(mem_op_t op, logic [31:0] addr, logic [4:0] rd);
        issue(op, 0, addr, 1'b0, 0, 1'b1, WB_MEM, rd, 1'b0);
        check_write(rd, extend(op, ref_mem[addr[31:2]]));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic test_reset_alu();
        check("rf_we", rf_we, 0);
        check("redirect", redirect, 0);
        check("stall", stall, 0);
        run_alu(5'd3, 32'hcafe_0123);
        run_alu(5'd0, 32'h5555_aaaa);    // x0 must not be written
    endtask

    task automatic test_store_load();
        for (int i = 0; i < 16; i++) begin
            run_store(MEM_SW, POOL_BASE + i * 4, rand_bits(32));
            if (i > 0)
                check("store stall in busy window", stall_cycles != 0, 1);
        end
        for (int i = 0; i < 16; i++)
            run_load(MEM_LW, POOL_BASE + i * 4, 5'(i + 1));
    endtask

    task automatic test_subword();
        run_store(MEM_SW, POOL_BASE, 32'h1122_3344);
        run_store(MEM_SB, POOL_BASE, 32'haabb_ccf5);
        run_load(MEM_LW, POOL_BASE, 5'd4);
        check("rf_wdata", rf_wdata, 32'h1122_33f5);
        run_store(MEM_SH, POOL_BASE, 32'h1234_8765);
        run_load(MEM_LW, POOL_BASE, 5'd4);
        check("rf_wdata", rf_wdata, 32'h1122_8765);
        run_load(MEM_LB, POOL_BASE, 5'd5);
        run_load(MEM_LBU, POOL_BASE, 5'd5);
        run_load(MEM_LH, POOL_BASE, 5'd6);
        check("rf_wdata", rf_wdata, 32'hffff_8765);
        run_load(MEM_LHU, POOL_BASE, 5'd7);
        run_store(MEM_SB, POOL_BASE, 32'h0000_009c);
        run_load(MEM_LB, POOL_BASE, 5'd8);
        check("rf_wdata", rf_wdata, 32'hffff_ff9c);
        run_load(MEM_LBU, POOL_BASE, 5'd9);
        run_store(MEM_SH, POOL_BASE, 32'hffff_1234);
        run_load(MEM_LH, POOL_BASE, 5'd10);
        run_load(MEM_LHU, POOL_BASE, 5'd11);
    endtask

    task automatic test_redirect();
        logic [31:0] jpc;
        jpc = pc_now;
        issue(MEM_NONE, 0, 32'h0000_0400, 1'b0, 0, 1'b1, WB_PC, 5'd1, 1'b1);
        expect_wb();
        check("rf_waddr", rf_waddr, 5'd1);
        check("rf_wdata", rf_wdata, jpc + 4);
        check("redirect", redirect, 1);
        check("redirect_pc", redirect_pc, 32'h0000_0400);
        bubble();
        issue(MEM_NONE, 0, 32'h0000_0123, 1'b1, 32'h0000_0800, 1'b0, WB_NONE, 5'd0, 1'b0);
        expect_wb();
        check("redirect_pc", redirect_pc, 32'h0000_0800);
        bubble();
    endtask

    task automatic test_flush();
        issue(MEM_NONE, 0, 0, 1'b1, 32'h0000_0900, 1'b0, WB_NONE, 5'd0, 1'b0);
        issue(MEM_NONE, 0, 32'h0000_dead, 1'b0, 0, 1'b1, WB_ALU, 5'd7, 1'b0);
        check("rf_we", rf_we, 0);
        issue(MEM_NONE, 0, 0, 1'b1, 32'h0000_0a00, 1'b0, WB_NONE, 5'd0, 1'b0);
        issue(MEM_SW, 32'hffff_ffff, POOL_BASE + 4, 1'b0, 0, 1'b0, WB_NONE, 5'd0, 1'b0);
        run_load(MEM_LW, POOL_BASE + 4, 5'd12);    // still the old word
    endtask

    task automatic test_random();
        logic [31:0] addr;
        logic [31:0] data;
        logic [4:0]  rd;
        for (int i = 0; i < 200; i++) begin
            addr = POOL_BASE + rand_bits(4) * 4;
            rd = 5'(rand_bits(5));
            data = rand_bits(32);
            case (rand_bits(3))
                0: run_alu(rd, data);
                1: run_store(MEM_SB, addr, data);
                2: run_store(MEM_SH, addr, data);
                3: run_store(MEM_SW, addr, data);
                4: run_load(MEM_LB, addr, rd);
                5: run_load(MEM_LBU, addr, rd);
                6: run_load(rand_bits(1) ? MEM_LH : MEM_LHU, addr, rd);
                default: run_load(MEM_LW, addr, rd);
            endcase
        end
    endtask

    initial begin
        rst_n = 1'b0;
        in_pc = '0;
        in_rs2_data = '0;
        in_alu_out = '0;
        in_br_target = '0;
        in_br_flg = 1'b0;
        in_rf_wen = 1'b0;
        in_jmp_flg = 1'b0;
        in_mem_op = MEM_NONE;
        in_wb_sel = WB_NONE;
        in_wb_addr = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset_alu();
        test_store_load();
        test_subword();
        test_redirect();
        test_flush();
        test_random();
        end_run();
    end

endmodule
